//--- common/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// width of every instruction address in the fetch path.
`define FETCH_AW 32

// One packet holds two 32-bit instructions.
`define FETCH_STEP 8

// index bits of the branch target cache, 16 entries.
`define BTAC_IW 4

`define RESET_PC 32'h0000_0000 // first fetch address after reset.

`endif

//--- common/fetch_pkg.sv
`default_nettype none
`include "fetch_defs.svh"

package fetch_pkg;

  typedef enum logic [1:0] {
    idle = 2'd0, // waiting for the first request after reset.
    busy = 2'd1,
    ctrl = 2'd2, // a redirect came while a request was outstanding.
    inv  = 2'd3  // same, for a fence.
  } fetch_state_t;

  // source of the next pc, listed from highest to lowest priority after seq.
  typedef enum logic [2:0] {
    none,
    seq,
    trap,
    mret,
    restore,
    predict,
    fence
  } redirect_t;

  typedef struct packed {
    fetch_state_t      state;
    imem_pkg::addr_t   pc;
    imem_pkg::packet_t rdata;
    logic              ready;
    logic              taken;
    imem_pkg::addr_t   taddr;
    imem_pkg::addr_t   tpc;
  } fetch_reg_t;

  localparam fetch_reg_t fetch_reg_init = '{
    state: idle, pc: `RESET_PC, rdata: '0, ready: 1'b0, taken: 1'b0, taddr: '0, tpc: '0
  };

endpackage

`default_nettype wire

//--- common/imem_pkg.sv
`default_nettype none
`include "fetch_defs.svh"

package imem_pkg;

  // width of a single instruction word.
  localparam int unsigned instr_w = 32;

  // number of instructions carried by one fetch packet.
  localparam int unsigned packet_n = 2;

  // request side: the byte address of a packet.
  typedef logic [`FETCH_AW-1:0] addr_t;

  // Response side. The lower word is the instruction at the packet address.
  typedef logic [packet_n*instr_w-1:0] packet_t;

endpackage

`default_nettype wire

//--- fetch/btac.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module btac (
  input  logic            clock,
  input  logic            reset,
  input  logic            clear,
  input  imem_pkg::addr_t get_pc,
  input  logic            upd_valid,
  input  imem_pkg::addr_t upd_pc,
  input  logic            upd_taken,
  input  imem_pkg::addr_t upd_target,
  output logic            pred_branch,
  output imem_pkg::addr_t pred_baddr,
  output logic            pred_rest,
  output imem_pkg::addr_t pred_raddr
);

  localparam int unsigned entries = 1 << `BTAC_IW;
  localparam int unsigned tag_w = `FETCH_AW - `BTAC_IW - 2;

  logic [entries-1:0] valid;
  logic [entries-1:0] taken;
  logic [tag_w-1:0]   tag [entries];
  imem_pkg::addr_t    target [entries];

  logic [`BTAC_IW-1:0] get_idx;
  logic [`BTAC_IW-1:0] upd_idx;
  logic [tag_w-1:0]    get_tag;
  logic [tag_w-1:0]    upd_tag;
  logic                upd_hit;
  logic                wrong_dir;
  logic                wrong_target;

  // entries are indexed by word address.
  assign get_idx = get_pc[`BTAC_IW+1:2];
  assign get_tag = get_pc[`FETCH_AW-1:`BTAC_IW+2];
  assign upd_idx = upd_pc[`BTAC_IW+1:2];
  assign upd_tag = upd_pc[`FETCH_AW-1:`BTAC_IW+2];

  assign pred_branch = valid[get_idx] && taken[get_idx] && (tag[get_idx] == get_tag);
  assign pred_baddr = target[get_idx];

  // Only a stored prediction can be wrong. A branch that misses is just learned.
  assign upd_hit = valid[upd_idx] && (tag[upd_idx] == upd_tag);
  assign wrong_dir = upd_taken != taken[upd_idx];
  assign wrong_target = upd_taken && (target[upd_idx] != upd_target);
  assign pred_rest = upd_valid && upd_hit && (wrong_dir || wrong_target);
  assign pred_raddr = upd_taken ? upd_target : upd_pc + `FETCH_STEP;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      valid <= '0;
    end else if (upd_valid) begin
      valid[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (upd_valid) begin
      tag[upd_idx] <= upd_tag;
      target[upd_idx] <= upd_target;
      taken[upd_idx] <= upd_taken; // a not taken outcome stays stored but never predicts.
    end
  end

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              trap,
  input  logic              mret,
  input  imem_pkg::addr_t   mtvec,
  input  imem_pkg::addr_t   mepc,
  input  logic              pred_branch,
  input  imem_pkg::addr_t   pred_baddr,
  input  logic              pred_rest,
  input  imem_pkg::addr_t   pred_raddr,
  input  logic              fence_valid,
  input  imem_pkg::addr_t   fence_npc,
  input  logic              stall,
  output imem_pkg::addr_t   get_pc,
  output logic              mem_valid,
  output logic              mem_spec,
  output imem_pkg::addr_t   mem_addr,
  input  logic              mem_ready,
  input  imem_pkg::packet_t mem_rdata,
  output imem_pkg::addr_t   next_pc,
  output imem_pkg::addr_t   fetch_pc,
  output imem_pkg::packet_t fetch_rdata,
  output logic              fetch_ready,
  output logic              fetch_taken,
  output imem_pkg::addr_t   fetch_taddr,
  output imem_pkg::addr_t   fetch_tpc
);

  fetch_pkg::fetch_reg_t r;
  fetch_pkg::fetch_reg_t v;
  fetch_pkg::redirect_t  redirect;
  logic run;     // set one cycle after reset is released.
  logic present; // a packet is held and no request is outstanding.
  logic advance;

  assign present = (r.state == fetch_pkg::busy) && r.ready;
  assign advance = present && !stall;

  always_comb begin
    if (trap) begin
      redirect = fetch_pkg::trap;
    end else if (mret) begin
      redirect = fetch_pkg::mret;
    end else if (pred_rest) begin
      redirect = fetch_pkg::restore;
    end else if (pred_branch && advance) begin
      redirect = fetch_pkg::predict; // replaces the sequential step.
    end else if (fence_valid) begin
      redirect = fetch_pkg::fence;
    end else if (advance) begin
      redirect = fetch_pkg::seq;
    end else begin
      redirect = fetch_pkg::none;
    end
  end

  always_comb begin
    v = r;
    mem_valid = 1'b0;
    mem_spec = 1'b0;

    if (redirect != fetch_pkg::none) begin
      v.taken = 1'b0;
      v.taddr = '0;
      v.tpc = '0;
    end
    case (redirect)
      fetch_pkg::trap:    v.pc = mtvec;
      fetch_pkg::mret:    v.pc = mepc;
      fetch_pkg::restore: v.pc = pred_raddr;
      fetch_pkg::fence:   v.pc = fence_npc;
      fetch_pkg::seq:     v.pc = r.pc + `FETCH_STEP;
      fetch_pkg::predict: begin
        v.pc = pred_baddr;
        v.taken = 1'b1;
        v.taddr = pred_baddr;
        v.tpc = r.pc;
      end
      default: begin
      end
    endcase

    case (r.state)
      fetch_pkg::idle: begin
        if (run) begin
          v.state = fetch_pkg::busy;
          mem_valid = 1'b1;
        end
      end
      fetch_pkg::busy: begin
        if (r.ready || mem_ready) begin
          // Nothing is outstanding any more, so a new pc goes out at once.
          if (redirect != fetch_pkg::none) begin
            v.ready = 1'b0; // an answer arriving with a redirect is dropped.
            mem_valid = 1'b1;
            mem_spec = (redirect != fetch_pkg::seq);
          end else if (mem_ready) begin
            v.ready = 1'b1;
            v.rdata = mem_rdata;
          end
        end else if (redirect == fetch_pkg::fence) begin
          v.state = fetch_pkg::inv;
        end else if (redirect != fetch_pkg::none) begin
          v.state = fetch_pkg::ctrl;
        end
      end
      default: begin
        // The stale answer is thrown away and the redirected pc issued with it.
        if (mem_ready) begin
          v.state = fetch_pkg::busy;
          mem_valid = 1'b1;
          mem_spec = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= fetch_pkg::fetch_reg_init;
      run <= 1'b0;
    end else begin
      r <= v;
      run <= 1'b1;
    end
  end

  assign mem_addr = v.pc;
  assign next_pc = v.pc;
  assign get_pc = r.pc;

  assign fetch_pc = r.pc;
  assign fetch_rdata = r.rdata;
  assign fetch_ready = r.ready;
  assign fetch_taken = r.taken;
  assign fetch_taddr = r.taddr;
  assign fetch_tpc = r.tpc;

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/imem_pkg.sv
common/fetch_pkg.sv
source/trap_vectors.sv
fetch/btac.sv
fetch/fetch_stage.sv
source/fetch_top.sv
test/fetch_assert.sv
test/fetch_tb.sv

//--- source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              cfg_we,
  input  logic              cfg_sel,
  input  imem_pkg::addr_t   cfg_wdata,
  input  logic              trap_req,
  input  logic              mret_req,
  input  logic              clear,
  input  logic              upd_valid,
  input  imem_pkg::addr_t   upd_pc,
  input  logic              upd_taken,
  input  imem_pkg::addr_t   upd_target,
  input  logic              fence_valid,
  input  imem_pkg::addr_t   fence_npc,
  input  logic              stall,
  output logic              mem_valid,
  output logic              mem_spec,
  output imem_pkg::addr_t   mem_addr,
  input  logic              mem_ready,
  input  imem_pkg::packet_t mem_rdata,
  output imem_pkg::addr_t   next_pc,
  output imem_pkg::addr_t   fetch_pc,
  output imem_pkg::packet_t fetch_rdata,
  output logic              fetch_ready,
  output logic              fetch_taken,
  output imem_pkg::addr_t   fetch_taddr,
  output imem_pkg::addr_t   fetch_tpc
);

  logic            trap;
  logic            mret;
  imem_pkg::addr_t mtvec;
  imem_pkg::addr_t mepc;
  imem_pkg::addr_t get_pc;
  logic            pred_branch;
  imem_pkg::addr_t pred_baddr;
  logic            pred_rest;
  imem_pkg::addr_t pred_raddr;

  trap_vectors vec0 (
    .clock, .reset, .cfg_we, .cfg_sel, .cfg_wdata, .trap_req, .mret_req,
    .trap, .mret, .mtvec, .mepc
  );

  btac btac0 (
    .clock, .reset, .clear, .get_pc, .upd_valid, .upd_pc, .upd_taken, .upd_target,
    .pred_branch, .pred_baddr, .pred_rest, .pred_raddr
  );

  fetch_stage fetch0 (
    .clock, .reset, .trap, .mret, .mtvec, .mepc,
    .pred_branch, .pred_baddr, .pred_rest, .pred_raddr,
    .fence_valid, .fence_npc, .stall, .get_pc,
    .mem_valid, .mem_spec, .mem_addr, .mem_ready, .mem_rdata,
    .next_pc, .fetch_pc, .fetch_rdata, .fetch_ready, .fetch_taken, .fetch_taddr, .fetch_tpc
  );

endmodule

`default_nettype wire

//--- source/trap_vectors.sv
`timescale 1ns/1ps
`default_nettype none

module trap_vectors (
  input  logic            clock,
  input  logic            reset,
  input  logic            cfg_we,
  input  logic            cfg_sel,
  input  imem_pkg::addr_t cfg_wdata,
  input  logic            trap_req,
  input  logic            mret_req,
  output logic            trap,
  output logic            mret,
  output imem_pkg::addr_t mtvec,
  output imem_pkg::addr_t mepc
);

  imem_pkg::addr_t aligned;

  // vectors point at whole words.
  assign aligned = {cfg_wdata[$bits(cfg_wdata)-1:2], 2'b00};

  always_ff @(posedge clock) begin
    if (!reset) begin
      trap <= 1'b0;
      mret <= 1'b0;
      mtvec <= '0;
      mepc <= '0;
    end else begin
      trap <= trap_req; // a write in the same cycle is seen together with the pulse.
      mret <= mret_req;
      if (cfg_we && !cfg_sel) begin
        mtvec <= aligned;
      end
      if (cfg_we && cfg_sel) begin
        mepc <= aligned;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/fetch_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assert (
  input logic            clock,
  input logic            reset,
  input logic            mem_valid,
  input logic            trap,
  input imem_pkg::addr_t mtvec,
  input imem_pkg::addr_t fetch_pc,
  input logic            fetch_ready
);

  // no request leaves while the block is held in reset.
  quiet_in_reset: assert property (@(posedge clock) !reset |-> !mem_valid)
    else $error("mem_valid is high during reset");

  // a packet is never shown in the cycle after its successor went out.
  no_stale_packet: assert property (@(posedge clock) disable iff (!reset)
    mem_valid |=> !fetch_ready)
    else $error("fetch_ready is high right after a new request");

  // trap sits on top of the redirect priority.
  trap_has_priority: assert property (@(posedge clock) disable iff (!reset)
    trap |=> (fetch_pc == $past(mtvec)))
    else $error("a trap pulse lost against another redirect source");

endmodule

bind fetch_stage fetch_assert assert0 (
  .clock(clock),
  .reset(reset),
  .mem_valid(mem_valid),
  .trap(trap),
  .mtvec(mtvec),
  .fetch_pc(fetch_pc),
  .fetch_ready(fetch_ready)
);

`default_nettype wire

//--- test/fetch_stim.txt
# name command a b c expected_fetch_pc, numbers in hex
# stall a=cycles; cfg a=sel b=data; trap a=with fence b=fence pc; train a=pc b=taken c=target; fence a=pc b=lead cycles
boot seq 0 0 0 00000000
step_1 seq 0 0 0 00000008
step_2 seq 0 0 0 00000010
hold stall 5 0 0 00000010
resume seq 0 0 0 00000018
set_mtvec cfg 0 100 0 00000020
trap_go trap 0 0 0 00000100
after_trap seq 0 0 0 00000108
set_mepc cfg 1 43 0 00000110
mret_go mret 0 0 0 00000040
after_mret seq 0 0 0 00000048
set_mtvec2 cfg 0 180 0 00000050
trap_vs_fence trap 1 300 0 00000180
step_3 seq 0 0 0 00000188
learn_branch train 200 1 400 00000190
jump_to_branch fence 200 1 0 00000200
take_branch seq 0 0 0 00000400
step_4 seq 0 0 0 00000408
flip_not_taken train 200 0 0 00000208
step_5 seq 0 0 0 00000210
flip_taken train 200 1 500 00000500
new_target train 200 1 600 00000600
step_6 seq 0 0 0 00000608
back_to_branch fence 200 1 0 00000200
take_again seq 0 0 0 00000600
fence_now fence 800 0 0 00000800
step_7 seq 0 0 0 00000808
hold_again stall 3 0 0 00000808
resume_again seq 0 0 0 00000810

//--- test/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_tb;

  localparam int packet_limit = 20; // cycles allowed for one packet to come back.

  logic              clock;
  logic              reset;
  logic              cfg_we, cfg_sel;
  imem_pkg::addr_t   cfg_wdata;
  logic              trap_req, mret_req;
  logic              clear;
  logic              upd_valid, upd_taken;
  imem_pkg::addr_t   upd_pc, upd_target;
  logic              fence_valid;
  imem_pkg::addr_t   fence_npc;
  logic              stall;
  logic              mem_valid, mem_spec;
  imem_pkg::addr_t   mem_addr;
  logic              mem_ready = 1'b0;
  imem_pkg::packet_t mem_rdata = '0;
  imem_pkg::addr_t   next_pc, fetch_pc, fetch_taddr, fetch_tpc;
  imem_pkg::packet_t fetch_rdata;
  logic              fetch_ready, fetch_taken;

  // memory model state.
  logic              pending = 1'b0;
  logic [1:0]        wait_left = 2'd0;
  logic [1:0]        delay;
  imem_pkg::addr_t   pend_addr = '0;
  logic [15:0]       lfsr = 16'd48;
  logic              have_last = 1'b0;
  imem_pkg::addr_t   last_addr = '0;
  logic              exp_spec;
  string             cur_name = "reset";

  // one entry per stimulus line.
  string             names[$];
  string             cmds[$];
  imem_pkg::addr_t   op_a[$], op_b[$], op_c[$], expect_pc[$];

  // every training seen so far, the latest one for a pc wins.
  imem_pkg::addr_t   train_pc[$], train_target[$];
  logic              train_taken[$];

  string             line, name_s, cmd_s;
  imem_pkg::addr_t   a, b, c, e;
  int                fd;
  int                errors = 0;
  int                errors_before;
  int                passed = 0;
  logic              loaded = 1'b0;
  imem_pkg::addr_t   prev_pc = '0;
  logic              exp_taken = 1'b0;
  imem_pkg::addr_t   exp_taddr = '0, exp_tpc = '0;
  imem_pkg::addr_t   exp_next;
  int                k_next;

  always #20 clock = ~clock;

  fetch_top dut0 (.*);

  // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  // A request is taken on a clock edge with mem_valid high and answered after
  // 0 to 3 idle cycles. A new request may come in the cycle of the answer.
  always @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
      wait_left <= 2'd0;
      have_last <= 1'b0;
    end else if (mem_valid) begin
      // only a request that does not follow the last one by a packet is speculative.
      exp_spec = have_last && (mem_addr != last_addr + `FETCH_STEP);
      check_flag(cur_name, "mem_spec", exp_spec, mem_spec);
      have_last <= 1'b1;
      last_addr <= mem_addr;
      delay[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      delay[1] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      pending <= 1'b1;
      pend_addr <= mem_addr;
      wait_left <= delay;
    end else if (mem_ready) begin
      pending <= 1'b0;
    end else if (pending && wait_left != 2'd0) begin
      wait_left <= wait_left - 2'd1;
    end
  end

  always @(negedge clock) begin
    mem_ready <= pending && (wait_left == 2'd0);
    mem_rdata <= {pend_addr, ~pend_addr}; // the packet is its address and the inverse.
  end

  function automatic int find_training(input imem_pkg::addr_t pc);
    int found;
    found = -1;
    for (int k = 0; k < train_pc.size(); k++) begin
      if (train_pc[k] == pc) found = k;
    end
    return found;
  endfunction

  task automatic check_addr(input string test, input string what,
                            input imem_pkg::addr_t expected, input imem_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("** Error %s: %s expected %h, actual %h", test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_packet(input string test, input imem_pkg::packet_t expected,
                              input imem_pkg::packet_t actual);
    if (actual !== expected) begin
      $display("** Error %s: fetch_rdata expected %h, actual %h", test, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error %s: %s expected %b, actual %b", test, what, expected, actual);
      errors++;
    end
  endtask

  // drives one command starting at a falling edge and ends on a falling edge.
  task automatic apply_command(input int i);
    if (cmds[i] == "stall") begin
      stall = 1'b1;
      repeat (op_a[i]) @(negedge clock);
    end else if (cmds[i] == "cfg") begin
      cfg_we = 1'b1;
      cfg_sel = op_a[i][0];
      cfg_wdata = op_b[i];
      @(negedge clock);
      cfg_we = 1'b0;
    end else if (cmds[i] == "trap") begin
      trap_req = 1'b1;
      @(negedge clock);
      trap_req = 1'b0;
      fence_valid = op_a[i][0]; // meets the trap pulse inside fetch_stage.
      fence_npc = op_b[i];
      @(negedge clock);
      fence_valid = 1'b0;
    end else if (cmds[i] == "mret") begin
      mret_req = 1'b1;
      @(negedge clock);
      mret_req = 1'b0;
    end else if (cmds[i] == "train") begin
      upd_valid = 1'b1;
      upd_pc = op_a[i];
      upd_taken = op_b[i][0];
      upd_target = op_c[i];
      @(negedge clock);
      upd_valid = 1'b0;
      train_pc.push_back(op_a[i]);
      train_taken.push_back(op_b[i][0]);
      train_target.push_back(op_c[i]);
    end else if (cmds[i] == "fence") begin
      repeat (op_b[i]) @(negedge clock); // lets a request go out first.
      fence_valid = 1'b1;
      fence_npc = op_a[i];
      @(negedge clock);
      fence_valid = 1'b0;
    end else if (cmds[i] == "seq") begin
      @(negedge clock);
    end else begin
      $display("test %s: unknown command %s in the stimulus file", names[i], cmds[i]);
      errors++;
    end
  endtask

  task automatic wait_packet(input string test);
    int cycles;
    cycles = 0;
    while (!fetch_ready && cycles < packet_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!fetch_ready) begin
      $display("test %s: no packet came back within %0d cycles", test, packet_limit);
      errors++;
    end
  endtask

  // A sequential step out of a pc with a taken training is predicted.
  // Every other command except a stall clears the prediction flags.
  task automatic expect_flags(input int i);
    int k;
    if (cmds[i] != "stall") begin
      exp_taken = 1'b0;
      exp_taddr = '0;
      exp_tpc = '0;
      k = find_training(prev_pc);
      if (cmds[i] == "seq" && k >= 0) begin
        if (train_taken[k]) begin
          exp_taken = 1'b1;
          exp_taddr = train_target[k];
          exp_tpc = prev_pc;
        end
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    cfg_we = 1'b0;
    cfg_sel = 1'b0;
    cfg_wdata = '0;
    trap_req = 1'b0;
    mret_req = 1'b0;
    clear = 1'b0;
    upd_valid = 1'b0;
    upd_taken = 1'b0;
    upd_pc = '0;
    upd_target = '0;
    fence_valid = 1'b0;
    fence_npc = '0;
    stall = 1'b0;
    fd = $fopen("test/fetch_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open test/fetch_stim.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%s %s %h %h %h %h", name_s, cmd_s, a, b, c, e) == 6) begin
            names.push_back(name_s);
            cmds.push_back(cmd_s);
            op_a.push_back(a);
            op_b.push_back(b);
            op_c.push_back(c);
            expect_pc.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
    if (names.size() == 0) begin
      $display("the stimulus file holds no tests");
      errors++;
    end
    loaded = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    for (int i = 0; i < names.size(); i++) begin
      errors_before = errors;
      cur_name = names[i];
      apply_command(i);
      wait_packet(names[i]);
      expect_flags(i);
      check_addr(names[i], "fetch_pc", expect_pc[i], fetch_pc);
      check_packet(names[i], {expect_pc[i], ~expect_pc[i]}, fetch_rdata);
      check_flag(names[i], "fetch_taken", exp_taken, fetch_taken);
      check_addr(names[i], "fetch_taddr", exp_taddr, fetch_taddr);
      check_addr(names[i], "fetch_tpc", exp_tpc, fetch_tpc);
      // with a packet held the next pc is a step, a prediction, or the same pc under stall.
      exp_next = expect_pc[i] + `FETCH_STEP;
      k_next = find_training(expect_pc[i]);
      if (k_next >= 0) begin
        if (train_taken[k_next]) begin
          exp_next = train_target[k_next];
        end
      end
      if (cmds[i] == "stall") begin
        exp_next = expect_pc[i];
      end
      check_addr(names[i], "next_pc", exp_next, next_pc);
      stall = 1'b0;
      prev_pc = expect_pc[i];
      if (errors == errors_before) begin
        passed++;
        $display("test %s: pass", names[i]);
      end else begin
        $display("test %s: fail", names[i]);
      end
    end
    $display("%0d tests run, %0d passed, %0d failed", names.size(), passed,
             names.size() - passed);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat ((names.size() + 1) * 20) @(posedge clock);
    $display("watchdog: the run did not end in time, the fetch path seems to hang");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
